// ==== src/div_cfg_pkg.sv ====
// Sizing constants for the integer divide unit.
// The queue depth equals max_inflight, so the issuer must never have more
// than max_inflight divides outstanding. The unit has no ready output.
// max_inflight is assumed to be a power of two.

package div_cfg_pkg;

    ////////////////////////////////////////////////////
    // Datapath sizing

    // Operand and result width
    localparam int xlen = 32;

    // Divides issued and not yet written back, also the queue depth
    localparam int max_inflight = 4;

    // Instruction id carried alongside each request
    localparam int id_width = 3;

    ////////////////////////////////////////////////////
    // Derived widths

    // Bit counter of the iterative divider
    localparam int count_width = $clog2(xlen);
    localparam int fifo_ptr_width = $clog2(max_inflight);
    // Occupancy must reach max_inflight itself
    localparam int fifo_count_width = $clog2(max_inflight + 1);

endpackage

// ==== src/div_types_pkg.sv ====
// Types shared by the divide unit and its issuer.
// Op encoding: bit 0 set selects unsigned, bit 1 set selects remainder.
// reuse_result is set by the issuer when the operands match the previous
// computed request; the unit does not check it.

package div_types_pkg;

    // Operand and result word
    typedef logic [div_cfg_pkg::xlen-1:0] word_t;

    // Instruction id returned with the result
    typedef logic [div_cfg_pkg::id_width-1:0] inst_id_t;

    typedef enum logic [1:0] {
        op_div  = 2'b00,
        op_divu = 2'b01,
        op_rem  = 2'b10,
        op_remu = 2'b11
    } div_op_t;

    // One queued divide request
    typedef struct packed {
        div_op_t  op;
        word_t    rs1;
        word_t    rs2;
        logic     reuse_result;
        inst_id_t id;
    } div_request_t;

    // Writeback strobe, done is high for one cycle
    typedef struct packed {
        word_t    rd;
        inst_id_t id;
        logic     done;
    } div_writeback_t;

    // Iterative divider states
    typedef enum logic {
        core_idle,
        core_busy
    } core_state_t;

endpackage

// ==== src/div_request_fifo.sv ====
// Circular request queue of max_inflight entries.
// Head is shown combinationally; a push into an empty queue is visible as
// head_valid one cycle later. Push and pop in one cycle keep the count.
// Entries carry no reset, only pointers and count are cleared.

`timescale 1ns/1ps

module div_request_fifo (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push,
    input  div_types_pkg::div_request_t push_data,
    input  logic                       pop,
    output div_types_pkg::div_request_t head,
    output logic                       head_valid
);

    import div_cfg_pkg::*;
    import div_types_pkg::*;

    div_request_t entries [max_inflight];

    logic [fifo_ptr_width-1:0]   rd_ptr;
    logic [fifo_ptr_width-1:0]   wr_ptr;
    logic [fifo_count_width-1:0] count;
    logic                        full;

    assign full = (count == fifo_count_width'(max_inflight));
    assign head_valid = (count != '0);
    assign head = entries[rd_ptr];

    ////////////////////////////////////////////////////
    // Storage

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_data;
        end
    end

    ////////////////////////////////////////////////////
    // Pointers and occupancy

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop cancel out
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////
    // Checks

    // Issuer exceeded max_inflight
    assert property (@(posedge clk) disable iff (rst) !(push && full))
        else $error("div_request_fifo: push while full");

    // Unit finished a divide that was never queued
    assert property (@(posedge clk) disable iff (rst) pop |-> head_valid)
        else $error("div_request_fifo: pop while empty");

endmodule

// ==== src/div_core.sv ====
// Unsigned restoring divider, one quotient bit per cycle.
// complete pulses exactly xlen cycles after start, for one cycle.
// The first step runs on the start edge straight from the input operands.
// Quotient and remainder hold until the next start, which reuse relies on.
// A zero divisor gives all ones and the dividend through the normal loop.

`timescale 1ns/1ps

module div_core (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  div_types_pkg::word_t dividend,
    input  div_types_pkg::word_t divisor,
    output div_types_pkg::word_t quotient,
    output div_types_pkg::word_t remainder,
    output logic                divisor_zero,
    output logic                complete
);

    import div_cfg_pkg::*;
    import div_types_pkg::*;

    core_state_t state;
    logic [count_width-1:0] bit_count;

    word_t divisor_q;
    word_t rem_q;
    // Dividend bits shift out the top as quotient bits shift in
    word_t quo_q;
    logic  zero_q;

    word_t         step_rem_in;
    word_t         step_quo_in;
    word_t         step_divisor;
    logic [xlen:0] shifted;
    logic [xlen:0] trial;
    word_t         step_rem;
    word_t         step_quo;

    ////////////////////////////////////////////////////
    // One restoring step

    always_comb begin
        // On start the step works on the fresh operands
        step_rem_in = start ? '0 : rem_q;
        step_quo_in = start ? dividend : quo_q;
        step_divisor = start ? divisor : divisor_q;

        shifted = {step_rem_in, step_quo_in[xlen-1]};
        trial = shifted - {1'b0, step_divisor};

        // Negative trial means restore the shifted remainder
        if (trial[xlen]) begin
            step_rem = shifted[xlen-1:0];
        end else begin
            step_rem = trial[xlen-1:0];
        end
        step_quo = {step_quo_in[xlen-2:0], ~trial[xlen]};
    end

    ////////////////////////////////////////////////////
    // Control FSM

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= core_idle;
            bit_count <= '0;
            complete <= 1'b0;
        end else begin
            complete <= 1'b0;
            case (state)
                core_idle: begin
                    if (start) begin
                        state <= core_busy;
                        // First bit already done on this edge
                        bit_count <= count_width'(1);
                    end
                end
                core_busy: begin
                    bit_count <= bit_count + 1'b1;
                    if (bit_count == count_width'(xlen - 1)) begin
                        state <= core_idle;
                        complete <= 1'b1;
                    end
                end
                default: state <= core_idle;
            endcase
        end
    end

    ////////////////////////////////////////////////////
    // Datapath registers

    always_ff @(posedge clk) begin
        if (start) begin
            divisor_q <= divisor;
            zero_q <= (divisor == '0);
        end
        if (start || state == core_busy) begin
            rem_q <= step_rem;
            quo_q <= step_quo;
        end
    end

    assign quotient = quo_q;
    assign remainder = remainder_sel();
    assign divisor_zero = zero_q;

    function automatic word_t remainder_sel();
        return rem_q;
    endfunction

    ////////////////////////////////////////////////////
    // Checks

    // Top level must hold off start until the previous divide completes
    assert property (@(posedge clk) disable iff (rst) (state == core_busy) |-> !start)
        else $error("div_core: start while busy");

    // One-cycle complete, exactly xlen cycles after start
    assert property (@(posedge clk) disable iff (rst)
                     start |-> ##xlen (complete ##1 !complete))
        else $error("div_core: complete not a single pulse xlen cycles after start");

endmodule

// ==== src/div_result_select.sv ====
// Output side of the divide unit.
// Picks quotient or remainder, restores the sign and registers the result.
// wb.done pulses one cycle after finish. No back-pressure is possible,
// so the consumer must take every strobe.

`timescale 1ns/1ps

module div_result_select (
    input  logic                         clk,
    input  logic                         rst,
    input  div_types_pkg::div_request_t  req,
    input  div_types_pkg::word_t         quotient,
    input  div_types_pkg::word_t         remainder,
    input  logic                         divisor_zero,
    input  logic                         finish,
    output div_types_pkg::div_writeback_t wb
);

    import div_cfg_pkg::*;
    import div_types_pkg::*;

    logic  signed_op;
    logic  want_remainder;
    logic  negate;
    word_t selected;
    word_t result;

    word_t    rd_q;
    inst_id_t id_q;
    logic     done_q;

    ////////////////////////////////////////////////////
    // Selection and sign correction

    assign signed_op = ~req.op[0];
    assign want_remainder = req.op[1];

    // Remainder follows the dividend sign
    // Quotient of a zero divisor stays all ones
    assign negate = want_remainder
        ? (signed_op & req.rs1[xlen-1])
        : (signed_op & (req.rs1[xlen-1] ^ req.rs2[xlen-1]) & ~divisor_zero);

    assign selected = want_remainder ? remainder : quotient;
    assign result = negate ? (~selected + 1'b1) : selected;

    ////////////////////////////////////////////////////
    // Writeback register

    always_ff @(posedge clk) begin
        if (finish) begin
            rd_q <= result;
            id_q <= req.id;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done_q <= 1'b0;
        end else begin
            done_q <= finish;
        end
    end

    assign wb.rd = rd_q;
    assign wb.id = id_q;
    assign wb.done = done_q;

endmodule

// ==== src/div_unit.sv ====
// Integer divide unit for DIV, DIVU, REM and REMU.
// No ready output: the issuer keeps at most max_inflight divides outstanding.
// Idle latency is 34 cycles from new_request to wb.done, 2 with reuse.
// Results leave strictly in issue order on a one-cycle wb.done strobe.
// Reuse requests read the divider's held quotient and remainder, so the
// issuer only sets reuse_result when the previous computed operands match.

`timescale 1ns/1ps

module div_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          new_request,
    input  div_types_pkg::div_request_t   request,
    output div_types_pkg::div_writeback_t wb
);

    import div_cfg_pkg::*;
    import div_types_pkg::*;

    div_request_t head;
    logic         head_valid;

    logic start;
    logic complete;
    logic div_done;
    logic in_progress;

    logic  signed_op;
    logic  rs1_negative;
    logic  rs2_negative;
    word_t dividend_mag;
    word_t divisor_mag;

    word_t quotient;
    word_t remainder;
    logic  divisor_zero;

    ////////////////////////////////////////////////////
    // Input side

    div_request_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (new_request),
        .push_data (request),
        .pop       (div_done),
        .head      (head),
        .head_valid(head_valid)
    );

    ////////////////////////////////////////////////////
    // Sequencing

    assign start = head_valid & ~in_progress & ~head.reuse_result;

    // Reuse finishes in the cycle the head appears
    assign div_done = complete | (head_valid & head.reuse_result);

    // Blocks a second start for the head already in the core
    always_ff @(posedge clk) begin
        if (rst) begin
            in_progress <= 1'b0;
        end else if (start) begin
            in_progress <= 1'b1;
        end else if (complete) begin
            in_progress <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////
    // Operand magnitudes

    assign signed_op = ~head.op[0];
    assign rs1_negative = signed_op & head.rs1[xlen-1];
    assign rs2_negative = signed_op & head.rs2[xlen-1];

    // Most negative value maps to itself, correct as unsigned
    assign dividend_mag = rs1_negative ? (~head.rs1 + 1'b1) : head.rs1;
    assign divisor_mag = rs2_negative ? (~head.rs2 + 1'b1) : head.rs2;

    div_core u_core (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .dividend    (dividend_mag),
        .divisor     (divisor_mag),
        .quotient    (quotient),
        .remainder   (remainder),
        .divisor_zero(divisor_zero),
        .complete    (complete)
    );

    ////////////////////////////////////////////////////
    // Output side

    div_result_select u_select (
        .clk         (clk),
        .rst         (rst),
        .req         (head),
        .quotient    (quotient),
        .remainder   (remainder),
        .divisor_zero(divisor_zero),
        .finish      (div_done),
        .wb          (wb)
    );

endmodule

// ==== tests/div_unit_tb.sv ====
// Testbench for the divide unit, table driven, results checked in issue order.
// Inputs change 1 ns after the rising edge; outputs are sampled on the falling edge.
// Issue is throttled so no more than max_inflight divides are outstanding.
// Reuse entries must directly follow a computed divide with the same operands.

`timescale 1ns/1ps

module div_unit_tb;

    import div_cfg_pkg::*;
    import div_types_pkg::*;

    // One table row: stimulus, expected rd and idle cycles before issue
    typedef struct packed {
        div_op_t    op;
        word_t      rs1;
        word_t      rs2;
        logic       reuse;
        word_t      expected;
        logic [7:0] gap;
    } test_entry_t;

    logic           clk;
    logic           rst;
    logic           new_request;
    div_request_t   request;
    div_writeback_t wb;

    test_entry_t tests [$];
    int issued = 0;
    int retired = 0;
    int pass_count = 0;
    int fail_count = 0;
    int error_count = 0;
    // Writeback strobe seen on the previous falling edge
    logic prev_done = 1'b0;

    div_unit u_dut (
        .clk        (clk),
        .rst        (rst),
        .new_request(new_request),
        .request    (request),
        .wb         (wb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////
    // Reference model and table helpers

    // RISC-V division rules, zero divisor and overflow included
    function automatic word_t expected_result(div_op_t op, word_t a, word_t b);
        logic signed [xlen-1:0] sa;
        logic signed [xlen-1:0] sb;
        logic                   overflow;
        sa = a;
        sb = b;
        overflow = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
        case (op)
            op_div:  return (b == '0) ? '1 : (overflow ? a : word_t'(sa / sb));
            op_divu: return (b == '0) ? '1 : a / b;
            op_rem:  return (b == '0) ? a : (overflow ? '0 : word_t'(sa % sb));
            default: return (b == '0) ? a : a % b;
        endcase
    endfunction

    task automatic add_entry(div_op_t op, word_t a, word_t b, logic reuse, word_t exp_rd,
                             int gap);
        test_entry_t entry;
        entry.op = op;
        entry.rs1 = a;
        entry.rs2 = b;
        entry.reuse = reuse;
        entry.expected = exp_rd;
        entry.gap = gap[7:0];
        tests.push_back(entry);
    endtask

    task automatic finish_run;
        $display("Tests: %0d passed, %0d failed, %0d other errors",
                 pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(string what);
        error_count++;
        $display("Timeout after 200 cycles while waiting for %s", what);
        finish_run();
    endtask

    ////////////////////////////////////////////////////
    // Writeback monitor

    always @(negedge clk) begin
        if (!rst && wb.done) begin
            if (retired >= issued) begin
                error_count++;
                $display("Writeback strobe seen with no request outstanding");
            end else if (wb.rd !== tests[retired].expected) begin
                fail_count++;
                $display("FAIL wb.rd entry %0d: got 0x%08h, expected 0x%08h",
                         retired, wb.rd, tests[retired].expected);
            end else if (wb.id !== inst_id_t'(retired % 8)) begin
                fail_count++;
                $display("FAIL wb.id entry %0d: got 0x%0h, expected 0x%0h",
                         retired, wb.id, retired % 8);
            end else if (tests[retired].reuse && !prev_done) begin
                // Reuse skips the divider, so it retires right behind its source
                error_count++;
                $display("Reuse entry %0d was not written back right after its source divide",
                         retired);
            end else begin
                pass_count++;
                $display("PASS entry %0d %s 0x%08h 0x%08h -> 0x%08h",
                         retired, tests[retired].op.name(), tests[retired].rs1,
                         tests[retired].rs2, wb.rd);
            end
            retired++;
        end
        prev_done = !rst && (wb.done === 1'b1);
    end

    ////////////////////////////////////////////////////
    // Stimulus

    initial begin
        int wait_cycles;
        int idle_left;
        int idle_pulses;
        int last_retired;
        word_t a;
        word_t b;
        div_op_t op;

        rst = 1'b1;
        new_request = 1'b0;
        request = '0;
        void'($urandom(32'h38110fa8));

        // Sign combinations, DIVU and remainders
        add_entry(op_div, 32'hFFFF_FFF9, 32'd2, 1'b0, 32'hFFFF_FFFD, 0);
        add_entry(op_div, 32'd7, 32'hFFFF_FFFE, 1'b0, 32'hFFFF_FFFD, 36);
        add_entry(op_div, 32'hFFFF_FFF9, 32'hFFFF_FFFE, 1'b0, 32'd3, 36);
        add_entry(op_div, 32'd7, 32'd2, 1'b0, 32'd3, 36);
        add_entry(op_divu, 32'hFFFF_FFF9, 32'd2, 1'b0, 32'h7FFF_FFFC, 36);
        add_entry(op_rem, 32'hFFFF_FFF9, 32'd2, 1'b0, 32'hFFFF_FFFF, 36);
        add_entry(op_rem, 32'd7, 32'hFFFF_FFFE, 1'b0, 32'd1, 36);
        add_entry(op_rem, 32'hFFFF_FFF9, 32'hFFFF_FFFE, 1'b0, 32'hFFFF_FFFF, 36);
        add_entry(op_remu, 32'hFFFF_FFF9, 32'd2, 1'b0, 32'd1, 36);
        // Zero divisor and overflow
        add_entry(op_div, 32'd100, 32'd0, 1'b0, 32'hFFFF_FFFF, 36);
        add_entry(op_divu, 32'd5, 32'd0, 1'b0, 32'hFFFF_FFFF, 36);
        add_entry(op_rem, 32'hFFFF_FFF7, 32'd0, 1'b0, 32'hFFFF_FFF7, 36);
        add_entry(op_remu, 32'h1234_5678, 32'd0, 1'b0, 32'h1234_5678, 36);
        add_entry(op_div, 32'h8000_0000, 32'hFFFF_FFFF, 1'b0, 32'h8000_0000, 36);
        add_entry(op_rem, 32'h8000_0000, 32'hFFFF_FFFF, 1'b0, 32'd0, 36);
        // Reuse of held remainder, -1000 by 7
        add_entry(op_div, 32'hFFFF_FC18, 32'd7, 1'b0, 32'hFFFF_FF72, 36);
        add_entry(op_rem, 32'hFFFF_FC18, 32'd7, 1'b1, 32'hFFFF_FFFA, 0);
        // Back-to-back burst, fifth entry has to wait for a slot
        add_entry(op_divu, 32'd1000, 32'd3, 1'b0, 32'h0000_014D, 40);
        add_entry(op_remu, 32'd1000, 32'd3, 1'b0, 32'd1, 0);
        add_entry(op_div, 32'hFFFF_FF9C, 32'd10, 1'b0, 32'hFFFF_FFF6, 0);
        add_entry(op_rem, 32'h7FFF_FFFF, 32'h10, 1'b0, 32'hF, 0);
        add_entry(op_divu, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0, 32'd1, 0);

        // Random entries, divisor shifted down for a spread of quotient sizes
        for (int k = 0; k < 6; k++) begin
            op = div_op_t'($urandom % 4);
            a = $urandom;
            b = $urandom >> ($urandom % 32);
            add_entry(op, a, b, 1'b0, expected_result(op, a, b), 0);
        end

        repeat (10) @(posedge clk);
        #1 rst = 1'b0;

        // Idle after reset, no strobe expected
        idle_pulses = 0;
        repeat (20) begin
            @(negedge clk);
            if (wb.done) begin
                idle_pulses++;
            end
        end
        if (idle_pulses != 0) begin
            error_count++;
            $display("Writeback strobe seen %0d times while idle after reset", idle_pulses);
        end else begin
            $display("PASS idle after reset, no writeback for 20 cycles");
        end

        for (int i = 0; i < tests.size(); i++) begin
            wait_cycles = 0;
            idle_left = tests[i].gap;
            while (idle_left != 0 || issued - retired >= max_inflight) begin
                @(posedge clk);
                #1 new_request = 1'b0;
                if (idle_left != 0) begin
                    idle_left--;
                end
                wait_cycles++;
                if (wait_cycles >= 200) begin
                    abort_on_timeout("a free request slot");
                end
            end
            @(posedge clk);
            #1;
            new_request = 1'b1;
            request.op = tests[i].op;
            request.rs1 = tests[i].rs1;
            request.rs2 = tests[i].rs2;
            request.reuse_result = tests[i].reuse;
            request.id = inst_id_t'(i % 8);
            issued++;
        end
        @(posedge clk);
        #1 new_request = 1'b0;

        // Drain, each writeback restarts the timeout
        wait_cycles = 0;
        last_retired = retired;
        while (retired < issued) begin
            @(posedge clk);
            wait_cycles = (retired != last_retired) ? 0 : wait_cycles + 1;
            last_retired = retired;
            if (wait_cycles >= 200) begin
                abort_on_timeout("the remaining writebacks");
            end
        end

        // Catch any extra strobe
        repeat (40) @(posedge clk);
        finish_run();
    end

endmodule

// ==== all.f ====
src/div_cfg_pkg.sv
src/div_types_pkg.sv
src/div_request_fifo.sv
src/div_core.sv
src/div_result_select.sv
src/div_unit.sv
tests/div_unit_tb.sv
